/* Bender.yml */
package:
  name: id_stage

sources:
  - hdl/id_pkg.sv
  - hdl/regfile.sv
  - hdl/instr_decode.sv
  - hdl/branch_execute.sv
  - hdl/branch_result.sv
  - hdl/id_stage_top.sv
  - target: test
    files:
      - bench/id_stage_assertions.sv
      - bench/id_stage_tb.sv

/* bench/id_stage_assertions.sv */
`timescale 1ns/100ps

module id_stage_assertions (
    input logic             clk,
    input logic             rst,
    input logic             req_i,
    input logic             ack_i,
    input id_pkg::id_resp_t resp_i
);
    int unsigned fail_cnt = 0;

    // ack only answers a request seen on the edge before
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_i) |-> $past(req_i))
    else begin
        fail_cnt++;
        $error("ack_o rose with no request pending");
    end

    // source still holding req keeps the DUT in ACK
    ack_held: assert property (@(posedge clk) disable iff (rst)
        (ack_i && req_i) |=> ack_i)
    else begin
        fail_cnt++;
        $error("ack_o dropped while req_i was still high");
    end

    // response frozen for the whole ack phase
    resp_stable: assert property (@(posedge clk) disable iff (rst)
        ack_i |=> (!ack_i || $stable(resp_i)))
    else begin
        fail_cnt++;
        $error("id_resp_o changed while ack_o was high");
    end

endmodule : id_stage_assertions

bind id_stage_top id_stage_assertions asrt0 (
    .clk    (clk),
    .rst    (rst),
    .req_i  (req_i),
    .ack_i  (ack_o),
    .resp_i (id_resp_o)
);

/* bench/id_stage_tb.sv */
`timescale 1ns/100ps

module id_stage_tb;
    import id_pkg::*;

    localparam int          SETUP_CYCLES = 40;
    localparam int          ROW_CYCLES   = 40;
    localparam logic [31:0] LFSR_TAPS    = 32'hA3000000;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_kind_e;
    typedef enum logic [1:0] {TGT_NONE, TGT_BR, TGT_JAL, TGT_JALR} tgt_kind_e;

    // flags are {br_en, flush, bht_mispredict, halt, load_regfile, mem_read, mem_write}
    typedef struct packed {
        word_t      instr;
        word_t      pc;
        logic       bubble;
        pred_t      pred;
        imm_kind_e  imm_kind;
        word_t      imm;
        tgt_kind_e  tgt_kind;
        pc_sel_e    sel;
        logic [6:0] flags;
        byte_en_t   ben;
        logic [1:0] hold;
    } row_t;

    logic        clk;
    logic        rst;
    logic        req;
    logic        ack;
    id_req_t     id_req;
    id_resp_t    id_resp;
    stats_t      stats;
    logic        wb_we;
    reg_idx_t    wb_rd;
    word_t       wb_data;
    word_t       model_regs [32];
    row_t        rows [$];
    logic        rows_ready;
    logic [31:0] lfsr_state;

    id_stage_top #(
        .NUM_REGS (32)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req),
        .ack_o     (ack),
        .id_req_i  (id_req),
        .id_resp_o (id_resp),
        .stats_o   (stats),
        .wb_we_i   (wb_we),
        .wb_rd_i   (wb_rd),
        .wb_data_i (wb_data)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "simulation aborted");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_sel(input string name, input pc_sel_e got, input pc_sel_e exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_stats(input string name, input stats_t got, input stats_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    function automatic word_t rand_word();
        word_t v;
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t encode_i_type(input logic [6:0] op, input reg_idx_t rd,
                                            input logic [2:0] f3, input reg_idx_t rs1,
                                            input word_t imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t encode_s_type(input logic [2:0] f3, input reg_idx_t rs1,
                                            input reg_idx_t rs2, input word_t imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encode_b_type(input logic [2:0] f3, input reg_idx_t rs1,
                                            input reg_idx_t rs2, input word_t imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t encode_u_type(input logic [6:0] op, input reg_idx_t rd,
                                            input word_t imm);
        return {imm[31:12], rd, op};
    endfunction

    function automatic word_t encode_j_type(input reg_idx_t rd, input word_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input word_t instr, input word_t pc, input logic bubble,
                           input pred_t pred, input imm_kind_e ik, input word_t imm,
                           input tgt_kind_e tk, input pc_sel_e sel, input logic [6:0] flags,
                           input byte_en_t ben, input logic [1:0] hold);
        row_t r;
        r.instr    = instr;
        r.pc       = pc;
        r.bubble   = bubble;
        r.pred     = pred;
        r.imm_kind = ik;
        r.imm      = imm;
        r.tgt_kind = tk;
        r.sel      = sel;
        r.flags    = flags;
        r.ben      = ben;
        r.hold     = hold;
        rows.push_back(r);
    endtask

    // x1 negative, x2 positive, x5 even, so branch outcomes are fixed
    task automatic build_table();
        add_row(encode_i_type(7'b0010011, 5'd9, 3'd0, 5'd3, -32'd5), 32'h100, 1'b0, 3'b000,
                IMM_I, -32'd5, TGT_NONE, pc_plus4, 7'b0000100, 4'h0, 2'd0);
        add_row(encode_i_type(7'b0000011, 5'd10, 3'd1, 5'd4, 32'h7f0), 32'h104, 1'b0, 3'b000,
                IMM_I, 32'h7f0, TGT_NONE, pc_plus4, 7'b0000110, 4'b0011, 2'd1);
        add_row(encode_s_type(3'd2, 5'd6, 5'd5, -32'd32), 32'h108, 1'b0, 3'b000,
                IMM_S, -32'd32, TGT_NONE, pc_plus4, 7'b0000001, 4'b1111, 2'd0);
        add_row(encode_u_type(7'b0110111, 5'd11, 32'habcde000), 32'h10c, 1'b0, 3'b000,
                IMM_U, 32'habcde000, TGT_NONE, pc_plus4, 7'b0000100, 4'h0, 2'd0);
        // x0 was written during setup and must still read zero
        add_row(encode_s_type(3'd0, 5'd0, 5'd0, 32'd8), 32'h110, 1'b0, 3'b000,
                IMM_S, 32'd8, TGT_NONE, pc_plus4, 7'b0000001, 4'b0001, 2'd0);
        add_row(encode_b_type(3'd0, 5'd3, 5'd3, 32'd16), 32'h200, 1'b0, 3'b001,
                IMM_B, 32'd16, TGT_BR, br_target, 7'b1100000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd0, 5'd1, 5'd2, 32'd16), 32'h210, 1'b0, 3'b001,
                IMM_B, 32'd16, TGT_BR, pc_plus4, 7'b0010000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd1, 5'd1, 5'd2, -32'd64), 32'h220, 1'b0, 3'b010,
                IMM_B, -32'd64, TGT_BR, br_target, 7'b1110000, 4'h0, 2'd2);
        add_row(encode_b_type(3'd1, 5'd3, 5'd3, -32'd64), 32'h230, 1'b0, 3'b010,
                IMM_B, -32'd64, TGT_BR, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd4, 5'd1, 5'd2, 32'd2048), 32'h240, 1'b0, 3'b001,
                IMM_B, 32'd2048, TGT_BR, br_target, 7'b1100000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd4, 5'd2, 5'd1, 32'd8), 32'h250, 1'b0, 3'b100,
                IMM_B, 32'd8, TGT_BR, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd5, 5'd2, 5'd1, -32'd8), 32'h260, 1'b0, 3'b000,
                IMM_B, -32'd8, TGT_BR, br_target, 7'b1110000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd5, 5'd1, 5'd2, 32'd12), 32'h270, 1'b0, 3'b001,
                IMM_B, 32'd12, TGT_BR, pc_plus4, 7'b0010000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd6, 5'd2, 5'd1, 32'd20), 32'h280, 1'b0, 3'b011,
                IMM_B, 32'd20, TGT_BR, br_target, 7'b1100000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd6, 5'd1, 5'd2, -32'd4096), 32'h2000, 1'b0, 3'b010,
                IMM_B, -32'd4096, TGT_BR, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd7, 5'd1, 5'd2, 32'd4094), 32'h2a0, 1'b0, 3'b000,
                IMM_B, 32'd4094, TGT_BR, br_target, 7'b1110000, 4'h0, 2'd3);
        add_row(encode_b_type(3'd7, 5'd2, 5'd1, 32'd4), 32'h2b0, 1'b0, 3'b001,
                IMM_B, 32'd4, TGT_BR, pc_plus4, 7'b0010000, 4'h0, 2'd0);
        add_row(encode_j_type(5'd1, 32'd4096), 32'h400, 1'b0, 3'b000,
                IMM_J, 32'd4096, TGT_JAL, br_target, 7'b1100100, 4'h0, 2'd0);
        add_row(encode_j_type(5'd5, -32'd2048), 32'h900, 1'b0, 3'b111,
                IMM_J, -32'd2048, TGT_JAL, br_target, 7'b1100100, 4'h0, 2'd0);
        add_row(encode_i_type(7'b1100111, 5'd1, 3'd0, 5'd5, 32'd7), 32'h500, 1'b0, 3'b000,
                IMM_I, 32'd7, TGT_JALR, jalr_target, 7'b1100100, 4'h0, 2'd1);
        add_row(encode_i_type(7'b1100111, 5'd7, 3'd0, 5'd6, -32'd3), 32'h504, 1'b0, 3'b000,
                IMM_I, -32'd3, TGT_JALR, jalr_target, 7'b1100100, 4'h0, 2'd0);
        // taken branch under a hazard bubble
        add_row(encode_b_type(3'd0, 5'd3, 5'd3, 32'd16), 32'h600, 1'b1, 3'b111,
                IMM_B, 32'd16, TGT_NONE, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        // bubbles on load, store and jump words
        add_row(encode_i_type(7'b0000011, 5'd12, 3'd2, 5'd8, 32'd4), 32'h604, 1'b1, 3'b000,
                IMM_I, 32'd4, TGT_NONE, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_s_type(3'd2, 5'd7, 5'd8, 32'd12), 32'h608, 1'b1, 3'b000,
                IMM_S, 32'd12, TGT_NONE, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_j_type(5'd1, 32'd256), 32'h60c, 1'b1, 3'b000,
                IMM_J, 32'd256, TGT_NONE, pc_plus4, 7'b0000000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd0, 5'd0, 5'd0, 32'd0), 32'h300, 1'b0, 3'b001,
                IMM_B, 32'd0, TGT_BR, br_target, 7'b1101000, 4'h0, 2'd0);
        add_row(encode_b_type(3'd0, 5'd0, 5'd0, 32'd0), 32'h0, 1'b0, 3'b001,
                IMM_B, 32'd0, TGT_BR, br_target, 7'b1100000, 4'h0, 2'd0);
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t val);
        @(negedge clk);
        wb_we   = 1'b1;
        wb_rd   = idx;
        wb_data = val;
        if (idx != '0) begin
            model_regs[idx] = val;
        end
    endtask

    task automatic apply_row(input row_t r);
        id_resp_t resp;
        word_t    exp_tgt;
        reg_idx_t rs1;
        reg_idx_t rs2;
        rs1 = r.instr[19:15];
        rs2 = r.instr[24:20];
        @(negedge clk);
        id_req.instr  = r.instr;
        id_req.pc     = r.pc;
        id_req.bubble = r.bubble;
        id_req.pred   = r.pred;
        req           = 1'b1;
        do begin
            @(negedge clk);
        end while (!ack);
        resp = id_resp;
        check_word("rs1_val", resp.rs1_val, model_regs[rs1]);
        check_word("rs2_val", resp.rs2_val, model_regs[rs2]);
        case (r.imm_kind)
            IMM_I:   check_word("i_imm", resp.i_imm, r.imm);
            IMM_S:   check_word("s_imm", resp.s_imm, r.imm);
            IMM_B:   check_word("b_imm", resp.b_imm, r.imm);
            IMM_U:   check_word("u_imm", resp.u_imm, r.imm);
            default: check_word("j_imm", resp.j_imm, r.imm);
        endcase
        if (r.tgt_kind != TGT_NONE) begin
            if (r.tgt_kind == TGT_JALR) begin
                exp_tgt = (model_regs[rs1] + r.imm) & ~32'h1;
            end else begin
                exp_tgt = r.pc + r.imm;
            end
            check_word("target", resp.target, exp_tgt);
        end
        check_sel("pc_sel", resp.pc_sel, r.sel);
        check_bit("br_en", resp.br_en, r.flags[6]);
        check_bit("flush", resp.flush, r.flags[5]);
        check_bit("bht_mispredict", resp.bht_mispredict, r.flags[4]);
        check_bit("halt", resp.halt, r.flags[3]);
        check_bit("ctrl.load_regfile", resp.ctrl.load_regfile, r.flags[2]);
        check_bit("ctrl.mem_read", resp.ctrl.mem_read, r.flags[1]);
        check_bit("ctrl.mem_write", resp.ctrl.mem_write, r.flags[0]);
        check_word("ctrl.mem_byte_en", word_t'(resp.ctrl.mem_byte_en), word_t'(r.ben));
        if (r.bubble) begin
            check_word("ctrl.opcode", word_t'(resp.ctrl.opcode), word_t'(op_csr));
        end
        // back-pressure: keep req high a few extra cycles
        repeat (r.hold) @(negedge clk);
        req = 1'b0;
        do begin
            @(negedge clk);
        end while (ack);
    endtask

    initial begin
        word_t  val;
        stats_t exp_stats;
        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        id_req     = '0;
        wb_we      = 1'b0;
        wb_rd      = '0;
        wb_data    = '0;
        lfsr_state = 32'd89;
        rows_ready = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        build_table();
        rows_ready = 1'b1;

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("ack_o", ack, 1'b0);
        check_bit("id_resp_o is zero", id_resp == '0, 1'b1);
        check_stats("stats_o", stats, '0);

        for (int i = 1; i <= 8; i++) begin
            val = rand_word();
            if (i == 1) begin
                val[31] = 1'b1;
            end
            if (i == 2) begin
                val[31] = 1'b0;
                val[0]  = 1'b1;
            end
            if (i == 5) begin
                val[0] = 1'b0;
            end
            write_reg(reg_idx_t'(i), val);
        end
        write_reg(5'd0, 32'hdeadbeef);
        @(negedge clk);
        wb_we = 1'b0;

        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        // counts follow from the table, bubbles never count
        exp_stats = '0;
        foreach (rows[i]) begin
            if (!rows[i].bubble && rows[i].instr[6:0] == op_br) begin
                exp_stats.total_br = exp_stats.total_br + 1'b1;
                if (rows[i].flags[6] != rows[i].pred.btfnt) begin
                    exp_stats.btfnt_mispredict = exp_stats.btfnt_mispredict + 1'b1;
                end
            end
            if (!rows[i].bubble && (rows[i].instr[6:0] == op_jal ||
                                    rows[i].instr[6:0] == op_jalr)) begin
                exp_stats.total_jump = exp_stats.total_jump + 1'b1;
            end
        end
        check_stats("stats_o", stats, exp_stats);

        if (dut0.asrt0.fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("%0d handshake assertion(s) failed", dut0.asrt0.fail_cnt);
            abort_run();
        end
    end

    // watchdog scaled to the table length
    initial begin
        int unsigned limit;
        wait (rows_ready);
        limit = SETUP_CYCLES + ROW_CYCLES * rows.size();
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        abort_run();
    end

endmodule : id_stage_tb

/* hdl/branch_execute.sv */
`timescale 1ns/100ps

module branch_execute (
    input  id_pkg::decode_t dec_i,
    input  id_pkg::word_t   rs1_val_i,
    input  id_pkg::word_t   rs2_val_i,
    input  id_pkg::word_t   pc_i,
    output logic            br_en_o,
    output id_pkg::word_t   target_o,
    output id_pkg::pc_sel_e pc_sel_o
);
    import id_pkg::*;

    word_t cmp_b;
    logic  cmp_res;
    word_t jalr_sum;

    // second operand is rs2 or the i-immediate
    assign cmp_b = dec_i.ctrl.cmp_imm_sel ? dec_i.i_imm : rs2_val_i;

    always_comb begin
        case (dec_i.ctrl.cmpop)
            beq:     cmp_res = (rs1_val_i == cmp_b);
            bne:     cmp_res = (rs1_val_i != cmp_b);
            blt:     cmp_res = ($signed(rs1_val_i) < $signed(cmp_b));
            bge:     cmp_res = ($signed(rs1_val_i) >= $signed(cmp_b));
            bltu:    cmp_res = (rs1_val_i < cmp_b);
            bgeu:    cmp_res = (rs1_val_i >= cmp_b);
            default: cmp_res = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_val_i + dec_i.i_imm;

    always_comb begin
        case (dec_i.ctrl.opcode)
            op_br: begin
                br_en_o  = cmp_res;
                target_o = pc_i + dec_i.b_imm;
                pc_sel_o = cmp_res ? br_target : pc_plus4;
            end
            op_jal: begin
                br_en_o  = 1'b1;
                target_o = pc_i + dec_i.j_imm;
                pc_sel_o = br_target;
            end
            op_jalr: begin
                br_en_o  = 1'b1;
                // lsb cleared as rv32i requires
                target_o = {jalr_sum[31:1], 1'b0};
                pc_sel_o = jalr_target;
            end
            default: begin
                br_en_o  = 1'b0;
                target_o = pc_i + 32'd4;
                pc_sel_o = pc_plus4;
            end
        endcase
    end

endmodule : branch_execute

/* hdl/branch_result.sv */
`timescale 1ns/100ps

module branch_result (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_i,
    output logic             ack_o,
    input  id_pkg::word_t    pc_i,
    input  id_pkg::pred_t    pred_i,
    input  id_pkg::decode_t  dec_i,
    input  id_pkg::word_t    rs1_val_i,
    input  id_pkg::word_t    rs2_val_i,
    input  id_pkg::word_t    target_i,
    input  logic             br_en_i,
    input  id_pkg::pc_sel_e  pc_sel_i,
    output id_pkg::id_resp_t resp_o,
    output id_pkg::stats_t   stats_o
);
    import id_pkg::*;

    typedef enum logic {
        IDLE,
        ACK
    } state_e;

    state_e   state_q;
    logic     capture;
    logic     is_br;
    logic     is_jump;
    logic     btfnt_miss;
    id_resp_t resp_d;
    id_resp_t resp_q;
    stats_t   stats_q;

    assign is_br   = (dec_i.ctrl.opcode == op_br);
    assign is_jump = (dec_i.ctrl.opcode == op_jal) || (dec_i.ctrl.opcode == op_jalr);

    assign btfnt_miss = is_br && (br_en_i != pred_i.btfnt);

    always_comb begin
        resp_d.ctrl    = dec_i.ctrl;
        resp_d.rs1_val = rs1_val_i;
        resp_d.rs2_val = rs2_val_i;
        resp_d.i_imm   = dec_i.i_imm;
        resp_d.s_imm   = dec_i.s_imm;
        resp_d.b_imm   = dec_i.b_imm;
        resp_d.u_imm   = dec_i.u_imm;
        resp_d.j_imm   = dec_i.j_imm;
        resp_d.target  = target_i;
        resp_d.pc_sel  = pc_sel_i;
        resp_d.br_en   = br_en_i;
        // target resolves too late for fetch, so any redirect flushes
        resp_d.flush          = (is_br && br_en_i) || is_jump;
        resp_d.bht_mispredict = is_br && (br_en_i != pred_i.local_bht);
        // branch to itself means the program spins
        resp_d.halt = br_en_i && (pc_i != '0) && (target_i == pc_i)
                      && (dec_i.ctrl.opcode != opcode_e'('0));
    end

    // four-phase handshake
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        state_q <= ACK;
                    end
                end
                ACK: begin
                    if (!req_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // only the first edge of a request captures
    assign capture = (state_q == IDLE) && req_i;
    assign ack_o   = (state_q == ACK);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_q  <= '0;
            stats_q <= '0;
        end else if (capture) begin
            resp_q                   <= resp_d;
            stats_q.total_br         <= stats_q.total_br + cnt_t'(is_br);
            stats_q.total_jump       <= stats_q.total_jump + cnt_t'(is_jump);
            stats_q.btfnt_mispredict <= stats_q.btfnt_mispredict + cnt_t'(btfnt_miss);
        end
    end

    assign resp_o  = resp_q;
    assign stats_o = stats_q;

endmodule : branch_result

/* hdl/id_pkg.sv */
package id_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int CNT_W     = 16;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [CNT_W-1:0]     cnt_t;
    typedef logic [3:0]           byte_en_t;

    // rv32i base opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_csr   = 7'b1110011
    } opcode_e;

    // funct3 of the conditional branches
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_e;

    typedef enum logic [1:0] {
        pc_plus4    = 2'b00,
        br_target   = 2'b01,
        jalr_target = 2'b10
    } pc_sel_e;

    typedef struct packed {
        logic static_nt;
        logic btfnt;
        logic local_bht;
    } pred_t;

    typedef struct packed {
        opcode_e        opcode;
        branch_funct3_e cmpop;
        logic           cmp_imm_sel;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        byte_en_t       mem_byte_en;
    } ctrl_word_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  bubble;
        pred_t pred;
    } id_req_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
    } decode_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        word_t      rs1_val;
        word_t      rs2_val;
        word_t      i_imm;
        word_t      s_imm;
        word_t      b_imm;
        word_t      u_imm;
        word_t      j_imm;
        word_t      target;
        pc_sel_e    pc_sel;
        logic       br_en;
        logic       flush;
        logic       bht_mispredict;
        logic       halt;
    } id_resp_t;

    typedef struct packed {
        cnt_t total_br;
        cnt_t total_jump;
        cnt_t btfnt_mispredict;
    } stats_t;

endpackage : id_pkg

/* hdl/id_stage_top.sv */
`timescale 1ns/100ps

module id_stage_top #(
    parameter int NUM_REGS = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_i,
    output logic             ack_o,
    input  id_pkg::id_req_t  id_req_i,
    output id_pkg::id_resp_t id_resp_o,
    output id_pkg::stats_t   stats_o,
    input  logic             wb_we_i,
    input  id_pkg::reg_idx_t wb_rd_i,
    input  id_pkg::word_t    wb_data_i
);
    import id_pkg::*;

    decode_t dec;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   target;
    logic    br_en;
    pc_sel_e pc_sel;

    instr_decode dec0 (
        .instr_i  (id_req_i.instr),
        .bubble_i (id_req_i.bubble),
        .dec_o    (dec)
    );

    regfile #(
        .NUM_REGS (NUM_REGS)
    ) rf0 (
        .clk        (clk),
        .rst        (rst),
        .we_i       (wb_we_i),
        .wr_idx_i   (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .rd_a_idx_i (dec.rs1),
        .rd_b_idx_i (dec.rs2),
        .rd_a_o     (rs1_val),
        .rd_b_o     (rs2_val)
    );

    // branches resolve here in decode
    branch_execute bex0 (
        .dec_i     (dec),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .pc_i      (id_req_i.pc),
        .br_en_o   (br_en),
        .target_o  (target),
        .pc_sel_o  (pc_sel)
    );

    branch_result bres0 (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req_i),
        .ack_o     (ack_o),
        .pc_i      (id_req_i.pc),
        .pred_i    (id_req_i.pred),
        .dec_i     (dec),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .target_i  (target),
        .br_en_i   (br_en),
        .pc_sel_i  (pc_sel),
        .resp_o    (id_resp_o),
        .stats_o   (stats_o)
    );

endmodule : id_stage_top

/* hdl/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode (
    input  id_pkg::word_t   instr_i,
    input  logic            bubble_i,
    output id_pkg::decode_t dec_o
);
    import id_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    byte_en_t   size_mask;
    ctrl_word_t ctrl;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // byte lanes from the access size in funct3
    always_comb begin
        case (funct3[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.opcode = opcode;
        ctrl.cmpop  = beq;
        case (opcode)
            op_lui, op_auipc, op_jal, op_jalr: begin
                ctrl.load_regfile = 1'b1;
            end
            op_br: begin
                ctrl.cmpop = branch_funct3_e'(funct3);
            end
            op_load: begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.mem_byte_en  = size_mask;
            end
            op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.mem_byte_en = size_mask;
            end
            op_imm: begin
                ctrl.load_regfile = 1'b1;
                // slti / sltiu compare against i_imm
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ctrl.cmpop       = funct3[0] ? bltu : blt;
                    ctrl.cmp_imm_sel = 1'b1;
                end
            end
            op_reg: begin
                ctrl.load_regfile = 1'b1;
                // slt / sltu only with the base funct7
                if (funct7 == 7'b0000000 && (funct3 == 3'b010 || funct3 == 3'b011)) begin
                    ctrl.cmpop = funct3[0] ? bltu : blt;
                end
            end
            default: begin
            end
        endcase

        // hazard bubble turns the word into a no-op
        if (bubble_i) begin
            ctrl.opcode       = op_csr;
            ctrl.load_regfile = 1'b0;
            ctrl.mem_read     = 1'b0;
            ctrl.mem_write    = 1'b0;
            ctrl.mem_byte_en  = '0;
        end
    end

    assign dec_o.ctrl  = ctrl;
    assign dec_o.rs1   = instr_i[19:15];
    assign dec_o.rs2   = instr_i[24:20];
    assign dec_o.rd    = instr_i[11:7];
    assign dec_o.i_imm = {{21{instr_i[31]}}, instr_i[30:20]};
    assign dec_o.s_imm = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
    assign dec_o.b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign dec_o.u_imm = {instr_i[31:12], 12'h000};
    assign dec_o.j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

endmodule : instr_decode

/* hdl/regfile.sv */
`timescale 1ns/100ps

module regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             we_i,
    input  id_pkg::reg_idx_t wr_idx_i,
    input  id_pkg::word_t    wr_data_i,
    input  id_pkg::reg_idx_t rd_a_idx_i,
    input  id_pkg::reg_idx_t rd_b_idx_i,
    output id_pkg::word_t    rd_a_o,
    output id_pkg::word_t    rd_b_o
);
    import id_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t            regs [NUM_REGS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_a_idx;
    logic [IDX_W-1:0] rd_b_idx;

    // upper index bits dropped for a smaller file (rv32e)
    assign wr_idx   = wr_idx_i[IDX_W-1:0];
    assign rd_a_idx = rd_a_idx_i[IDX_W-1:0];
    assign rd_b_idx = rd_b_idx_i[IDX_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_idx != '0)) begin
            regs[wr_idx] <= wr_data_i;
        end
    end

    // x0 hardwired to zero
    assign rd_a_o = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
    assign rd_b_o = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

endmodule : regfile

/* id_stage.f */
hdl/id_pkg.sv
hdl/regfile.sv
hdl/instr_decode.sv
hdl/branch_execute.sv
hdl/branch_result.sv
hdl/id_stage_top.sv
bench/id_stage_assertions.sv
bench/id_stage_tb.sv
